// ==== source/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Address of the first fetch after reset
`define RV_RESET_PC 32'h0000_0000

// Architectural integer registers
`define RV_NUM_REGS 32

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// ==== source/rv_pkg.sv ====
package rv_pkg;

  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_t;

  typedef enum logic {
    SRC_B_REG,
    SRC_B_IMM
  } alu_src_b_t;

  // Writeback value source
  typedef enum logic [1:0] {
    RESULT_ALU,
    RESULT_LOAD,
    RESULT_PC4
  } result_src_t;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_JAL
  } branch_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
    data_t instr;
  } if_to_id_t;

  typedef struct packed {
    logic        valid;
    addr_t       pc;
    data_t       rd1;
    data_t       rd2;
    data_t       imm_ext;
    reg_idx_t    rd;
    alu_op_t     alu_op;
    alu_src_b_t  alu_src_b;
    result_src_t result_src;
    branch_t     branch;
    logic        mem_write;
    logic        reg_write;
  } id_to_ex_t;

  typedef struct packed {
    logic        valid;
    data_t       alu_result;
    data_t       store_data;
    addr_t       pc_plus4;
    reg_idx_t    rd;
    result_src_t result_src;
    logic        mem_write;
    logic        reg_write;
  } ex_to_mem_t;

  // Execute back to fetch
  typedef struct packed {
    logic  taken;
    addr_t target;
  } redirect_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } dmem_req_t;

  typedef struct packed {
    logic     enable;
    reg_idx_t rd;
    data_t    value;
  } wb_t;

endpackage

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  rv_pkg::data_t   a,
  input  rv_pkg::data_t   b,
  input  rv_pkg::alu_op_t op,
  output rv_pkg::data_t   result,
  output logic            zero,
  output logic            less,
  output logic            less_u
);

  logic [4:0] shamt;

  assign shamt  = b[4:0];
  // Compare flags come straight from the operands
  assign less   = $signed(a) < $signed(b);
  assign less_u = a < b;
  assign zero   = (result == '0);

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:  result = a + b;
      rv_pkg::ALU_SUB:  result = a - b;
      rv_pkg::ALU_AND:  result = a & b;
      rv_pkg::ALU_OR:   result = a | b;
      rv_pkg::ALU_XOR:  result = a ^ b;
      rv_pkg::ALU_SLT:  result = {31'b0, less};
      rv_pkg::ALU_SLTU: result = {31'b0, less_u};
      rv_pkg::ALU_SLL:  result = a << shamt;
      rv_pkg::ALU_SRL:  result = a >> shamt;
      rv_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
      default:          result = a + b;
    endcase
  end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module register_file (
  input  logic             clk,
  input  logic             reset,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  output rv_pkg::data_t    rs1_val,
  output rv_pkg::data_t    rs2_val,
  input  rv_pkg::wb_t      wb
);

  rv_pkg::data_t regs [`RV_NUM_REGS];

  // x0 reads zero and a same-cycle write passes straight through
  always_comb begin
    if (rs1_idx == 5'd0) begin
      rs1_val = '0;
    end else if (wb.enable && wb.rd == rs1_idx) begin
      rs1_val = wb.value;
    end else begin
      rs1_val = regs[rs1_idx];
    end
  end

  always_comb begin
    if (rs2_idx == 5'd0) begin
      rs2_val = '0;
    end else if (wb.enable && wb.rd == rs2_idx) begin
      rs2_val = wb.value;
    end else begin
      rs2_val = regs[rs2_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.enable && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.value;
    end
  end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module fetch_stage (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::redirect_t redirect,
  output rv_pkg::addr_t     imem_addr,
  input  rv_pkg::data_t     imem_data,
  output rv_pkg::if_to_id_t if_to_id
);

  rv_pkg::addr_t pc;

  // Redirect target is fetched in the same cycle it arrives
  assign imem_addr = redirect.taken ? redirect.target : pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc             <= `RV_RESET_PC;
      if_to_id.valid <= 1'b0;
    end else begin
      pc             <= imem_addr + 32'd4;
      if_to_id.valid <= 1'b1;
    end
    if_to_id.pc    <= imem_addr;
    if_to_id.instr <= imem_data;
  end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module decode_stage (
  input  logic              clk,
  input  logic              reset,
  input  rv_pkg::if_to_id_t if_to_id,
  input  logic              redirect_taken,
  output rv_pkg::reg_idx_t  rs1_idx,
  output rv_pkg::reg_idx_t  rs2_idx,
  input  rv_pkg::data_t     rs1_val,
  input  rv_pkg::data_t     rs2_val,
  output rv_pkg::id_to_ex_t id_to_ex
);

  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  rv_pkg::data_t     instr;
  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic              alt;
  logic              supported;
  rv_pkg::alu_op_t   arith_op;
  rv_pkg::id_to_ex_t id_next;

  // Bubbles decode as a NOP
  assign instr   = if_to_id.valid ? if_to_id.instr : `RV_NOP;
  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign alt     = instr[30];
  // lui adds its immediate to x0
  assign rs1_idx = (opcode == OP_LUI) ? 5'd0 : instr[19:15];
  assign rs2_idx = instr[24:20];

  // Shared by register and immediate arithmetic
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (alt && opcode == OP_REG) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
      3'b001:  arith_op = rv_pkg::ALU_SLL;
      3'b010:  arith_op = rv_pkg::ALU_SLT;
      3'b011:  arith_op = rv_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_pkg::ALU_XOR;
      3'b101:  arith_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  arith_op = rv_pkg::ALU_OR;
      default: arith_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    id_next           = '0;
    id_next.pc        = if_to_id.pc;
    id_next.rd1       = rs1_val;
    id_next.rd2       = rs2_val;
    id_next.rd        = instr[11:7];
    id_next.alu_op    = rv_pkg::ALU_ADD;
    id_next.alu_src_b = rv_pkg::SRC_B_IMM;
    supported         = 1'b1;
    case (opcode)
      OP_REG: begin
        id_next.alu_op    = arith_op;
        id_next.alu_src_b = rv_pkg::SRC_B_REG;
        id_next.reg_write = 1'b1;
      end
      OP_IMM: begin
        id_next.imm_ext   = {{20{instr[31]}}, instr[31:20]};
        id_next.alu_op    = arith_op;
        id_next.reg_write = 1'b1;
      end
      OP_LUI: begin
        id_next.imm_ext   = {instr[31:12], 12'b0};
        id_next.reg_write = 1'b1;
      end
      OP_LOAD: begin
        id_next.imm_ext    = {{20{instr[31]}}, instr[31:20]};
        id_next.result_src = rv_pkg::RESULT_LOAD;
        id_next.reg_write  = 1'b1;
        supported          = (funct3 == 3'b010);
      end
      OP_STORE: begin
        id_next.imm_ext   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        id_next.mem_write = 1'b1;
        supported         = (funct3 == 3'b010);
      end
      OP_BRANCH: begin
        id_next.imm_ext   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                             instr[11:8], 1'b0};
        id_next.alu_op    = rv_pkg::ALU_SUB;
        id_next.alu_src_b = rv_pkg::SRC_B_REG;
        case (funct3)
          3'b000:  id_next.branch = rv_pkg::BR_BEQ;
          3'b001:  id_next.branch = rv_pkg::BR_BNE;
          3'b100:  id_next.branch = rv_pkg::BR_BLT;
          3'b101:  id_next.branch = rv_pkg::BR_BGE;
          default: supported = 1'b0;
        endcase
      end
      OP_JAL: begin
        id_next.imm_ext    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
        id_next.branch     = rv_pkg::BR_JAL;
        id_next.result_src = rv_pkg::RESULT_PC4;
        id_next.reg_write  = 1'b1;
      end
      default: supported = 1'b0;
    endcase
    // Wrong-path word behind a taken branch
    id_next.valid = if_to_id.valid && supported && !redirect_taken;
  end

  always_ff @(posedge clk) begin
    id_to_ex <= id_next;
    if (reset) begin
      id_to_ex.valid <= 1'b0;
    end
  end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic               clk,
  input  logic               reset,
  input  rv_pkg::id_to_ex_t  id_to_ex,
  output rv_pkg::ex_to_mem_t ex_to_mem,
  output rv_pkg::redirect_t  redirect
);

  rv_pkg::data_t alu_b;
  rv_pkg::data_t alu_result;
  rv_pkg::addr_t target;
  logic          zero;
  logic          less;
  logic          take;
  logic          live;

  always_comb begin
    case (id_to_ex.alu_src_b)
      rv_pkg::SRC_B_REG: alu_b = id_to_ex.rd2;
      default:           alu_b = id_to_ex.imm_ext;
    endcase
  end

  assign target = id_to_ex.pc + id_to_ex.imm_ext;

  alu u_alu (
    .a      (id_to_ex.rd1),
    .b      (alu_b),
    .op     (id_to_ex.alu_op),
    .result (alu_result),
    .zero   (zero),
    .less   (less),
    .less_u ()
  );

  // Branch outcome from the subtract flags
  always_comb begin
    case (id_to_ex.branch)
      rv_pkg::BR_BEQ: take = zero;
      rv_pkg::BR_BNE: take = !zero;
      rv_pkg::BR_BLT: take = less;
      rv_pkg::BR_BGE: take = !less;
      rv_pkg::BR_JAL: take = 1'b1;
      default:        take = 1'b0;
    endcase
  end

  // A redirect in flight means this one is on the wrong path
  assign live = id_to_ex.valid && !redirect.taken;

  always_ff @(posedge clk) begin
    ex_to_mem.valid      <= live;
    ex_to_mem.alu_result <= alu_result;
    ex_to_mem.store_data <= id_to_ex.rd2;
    ex_to_mem.pc_plus4   <= id_to_ex.pc + 32'd4;
    ex_to_mem.rd         <= id_to_ex.rd;
    ex_to_mem.result_src <= id_to_ex.result_src;
    ex_to_mem.mem_write  <= id_to_ex.mem_write;
    ex_to_mem.reg_write  <= id_to_ex.reg_write;
    redirect.taken       <= live && take;
    redirect.target      <= target;
    if (reset) begin
      ex_to_mem.valid <= 1'b0;
      redirect.taken  <= 1'b0;
    end
  end

endmodule

// ==== source/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
  input  rv_pkg::ex_to_mem_t ex_to_mem,
  output rv_pkg::dmem_req_t  dmem_req,
  input  rv_pkg::data_t      dmem_rdata,
  output rv_pkg::wb_t        wb
);

  logic          is_load;
  rv_pkg::data_t wb_value;

  assign is_load = (ex_to_mem.result_src == rv_pkg::RESULT_LOAD);

  // One strobe per valid load or store, accepted at once
  always_comb begin
    dmem_req.valid = ex_to_mem.valid && (ex_to_mem.mem_write || is_load);
    dmem_req.write = ex_to_mem.mem_write;
    dmem_req.addr  = ex_to_mem.alu_result;
    dmem_req.wdata = ex_to_mem.store_data;
  end

  always_comb begin
    case (ex_to_mem.result_src)
      rv_pkg::RESULT_LOAD: wb_value = dmem_rdata;
      rv_pkg::RESULT_PC4:  wb_value = ex_to_mem.pc_plus4;
      default:             wb_value = ex_to_mem.alu_result;
    endcase
  end

  // Writes to x0 are dropped here
  always_comb begin
    wb.enable = ex_to_mem.valid && ex_to_mem.reg_write && (ex_to_mem.rd != 5'd0);
    wb.rd     = ex_to_mem.rd;
    wb.value  = wb_value;
  end

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
  input  logic              clk,
  input  logic              reset,
  output rv_pkg::addr_t     imem_addr,
  input  rv_pkg::data_t     imem_data,
  output rv_pkg::dmem_req_t dmem_req,
  input  rv_pkg::data_t     dmem_rdata
);

  rv_pkg::if_to_id_t  if_to_id;
  rv_pkg::id_to_ex_t  id_to_ex;
  rv_pkg::ex_to_mem_t ex_to_mem;
  rv_pkg::redirect_t  redirect;
  rv_pkg::wb_t        wb;
  rv_pkg::reg_idx_t   rs1_idx;
  rv_pkg::reg_idx_t   rs2_idx;
  rv_pkg::data_t      rs1_val;
  rv_pkg::data_t      rs2_val;

  fetch_stage u_fetch (
    .clk       (clk),
    .reset     (reset),
    .redirect  (redirect),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .if_to_id  (if_to_id)
  );

  decode_stage u_decode (
    .clk            (clk),
    .reset          (reset),
    .if_to_id       (if_to_id),
    .redirect_taken (redirect.taken),
    .rs1_idx        (rs1_idx),
    .rs2_idx        (rs2_idx),
    .rs1_val        (rs1_val),
    .rs2_val        (rs2_val),
    .id_to_ex       (id_to_ex)
  );

  register_file u_regs (
    .clk     (clk),
    .reset   (reset),
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .wb      (wb)
  );

  execute_stage u_execute (
    .clk       (clk),
    .reset     (reset),
    .id_to_ex  (id_to_ex),
    .ex_to_mem (ex_to_mem),
    .redirect  (redirect)
  );

  memory_stage u_memory (
    .ex_to_mem  (ex_to_mem),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .wb         (wb)
  );

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
  output logic clk
);

  // 10 ns period
  localparam int HALF_PERIOD = 5;

  initial begin
    clk = 1'b0;
  end

  always #HALF_PERIOD clk = ~clk;

endmodule

// ==== testbench/core_tb.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module core_tb;

  localparam int RESET_CYCLES  = 16;
  localparam int STORE_TIMEOUT = 500;
  localparam logic [6:0] OP_IMM  = 7'b0010011;
  localparam logic [6:0] OP_LOAD = 7'b0000011;

  logic              clk;
  logic              reset;
  rv_pkg::addr_t     imem_addr;
  rv_pkg::data_t     imem_data;
  rv_pkg::dmem_req_t dmem_req;
  rv_pkg::data_t     dmem_rdata;

  rv_pkg::data_t     imem [256];
  rv_pkg::data_t     dmem [256];
  rv_pkg::dmem_req_t store_log [$];
  rv_pkg::dmem_req_t expected [$];
  int                strobes;
  int                prog_len;
  int                test_errors;
  int                errors;
  int                tests_run;
  int                tests_failed;
  int                seed;

  clock_gen clock (.clk(clk));

  rv_core uut (
    .clk        (clk),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata)
  );

  // Both memories answer in the same cycle
  assign imem_data  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_req.addr[9:2]];

  // Every strobe is accepted at once and stores are logged in order
  always @(negedge clk) begin
    if (!reset && dmem_req.valid) begin
      strobes++;
      if (dmem_req.write) begin
        dmem[dmem_req.addr[9:2]] = dmem_req.wdata;
        store_log.push_back(dmem_req);
      end
    end
  end

  function automatic rv_pkg::data_t enc_r(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
                                          input rv_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                          input rv_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv_pkg::data_t enc_i(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                          input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
                                          input logic [6:0] opcode);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  function automatic rv_pkg::data_t enc_s(input logic [11:0] imm, input rv_pkg::reg_idx_t rs2,
                                          input rv_pkg::reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv_pkg::data_t enc_b(input logic [12:0] imm, input rv_pkg::reg_idx_t rs2,
                                          input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv_pkg::data_t enc_u(input logic [19:0] imm, input rv_pkg::reg_idx_t rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic rv_pkg::data_t enc_j(input logic [20:0] imm, input rv_pkg::reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic rv_pkg::data_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // lui part that survives the sign extended addi low part
  function automatic logic [19:0] upper_part(input rv_pkg::data_t v);
    rv_pkg::data_t rounded;
    rounded = v + 32'h800;
    return rounded[31:12];
  endfunction

  // RV32I arithmetic by funct3 with alt selecting sub and sra
  function automatic rv_pkg::data_t alu_model(input logic [2:0] f3, input logic alt,
                                              input rv_pkg::data_t a, input rv_pkg::data_t b);
    rv_pkg::data_t r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input rv_pkg::data_t a,
                                        input rv_pkg::data_t b);
    logic t;
    case (f3)
      3'b000:  t = (a == b);
      3'b001:  t = (a != b);
      3'b100:  t = ($signed(a) < $signed(b));
      default: t = ($signed(a) >= $signed(b));
    endcase
    return t;
  endfunction

  task automatic clear_memories();
    for (int i = 0; i < 256; i++) begin
      imem[i] = `RV_NOP;
      dmem[i] = 32'hD0D0_0000 | (i << 2);
    end
    store_log.delete();
    expected.delete();
    strobes  = 0;
    prog_len = 0;
  endtask

  // Program is loaded while the core sits in reset
  task automatic begin_program();
    @(negedge clk);
    reset = 1'b1;
    @(negedge clk);
    clear_memories();
    test_errors = 0;
  endtask

  task automatic release_reset();
    repeat (RESET_CYCLES - 1) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic put(input rv_pkg::data_t instr);
    imem[prog_len] = instr;
    prog_len++;
  endtask

  // lui then addi for two registers with each addi two slots after its lui
  task automatic put_pair(input rv_pkg::reg_idx_t r1, input rv_pkg::data_t v1,
                          input rv_pkg::reg_idx_t r2, input rv_pkg::data_t v2);
    put(enc_u(upper_part(v1), r1));
    put(enc_u(upper_part(v2), r2));
    put(enc_i(v1[11:0], r1, 3'b000, r1, OP_IMM));
    put(enc_i(v2[11:0], r2, 3'b000, r2, OP_IMM));
  endtask

  task automatic put_sw(input rv_pkg::reg_idx_t rs2, input logic [11:0] addr,
                        input rv_pkg::data_t data, input logic keep);
    rv_pkg::dmem_req_t req;
    put(enc_s(addr, rs2, 5'd0));
    if (keep) begin
      req.valid = 1'b1;
      req.write = 1'b1;
      req.addr  = sext12(addr);
      req.wdata = data;
      expected.push_back(req);
    end
  endtask

  // Parks the core on a jump to itself
  task automatic finish_program();
    put(enc_j(21'd0, 5'd0));
  endtask

  task automatic check_store(input rv_pkg::dmem_req_t got, input rv_pkg::dmem_req_t want);
    if (got.addr !== want.addr || got.wdata !== want.wdata) begin
      $display("** Error at %0t: store wrote %h to %h, expected %h to %h", $time,
               got.wdata, got.addr, want.wdata, want.addr);
      test_errors++;
    end
  endtask

  task automatic check_fetch(input rv_pkg::addr_t want, input string what);
    if (imem_addr !== want) begin
      $display("** Error at %0t: %s fetch address %h, expected %h", $time, what,
               imem_addr, want);
      test_errors++;
    end
  endtask

  task automatic collect_stores(input string name, input int loads);
    int cycles;
    cycles = 0;
    while (store_log.size() < expected.size() && cycles < STORE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (store_log.size() < expected.size()) begin
      $display("%s: timed out after %0d cycles with %0d of %0d stores seen", name, cycles,
               store_log.size(), expected.size());
      test_errors++;
    end else begin
      // Time for a stray store to show up
      repeat (8) @(negedge clk);
      foreach (expected[i]) begin
        check_store(store_log[i], expected[i]);
      end
      if (store_log.size() != expected.size() || strobes != expected.size() + loads) begin
        $display("%s: saw %0d stores and %0d strobes, expected %0d stores and %0d strobes",
                 name, store_log.size(), strobes, expected.size(), expected.size() + loads);
        test_errors++;
      end
    end
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, test_errors);
    end
  endtask

  task automatic test_reset_fetch();
    rv_pkg::data_t a;
    rv_pkg::data_t b;
    begin_program();
    a = $urandom();
    b = $urandom();
    put_pair(5'd1, a, 5'd2, b);
    put(`RV_NOP);
    put(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    put(`RV_NOP);
    put_sw(5'd3, 12'h0F0, a + b, 1'b1);
    finish_program();
    release_reset();
    check_fetch(`RV_RESET_PC, "first");
    @(negedge clk);
    check_fetch(`RV_RESET_PC + 32'd4, "second");
    collect_stores("reset and first store", 0);
  endtask

  task automatic test_alu_ops();
    rv_pkg::data_t a;
    rv_pkg::data_t b;
    logic [11:0]   imm;
    logic [19:0]   upper;
    logic [11:0]   addr;
    logic [2:0]    f3;
    logic          alt;
    begin_program();
    a    = $urandom();
    b    = $urandom();
    addr = 12'h100;
    put_pair(5'd1, a, 5'd2, b);
    put(`RV_NOP);
    for (int k = 0; k < 16; k++) begin
      f3  = 3'(k / 2);
      alt = 1'(k % 2);
      if (!alt || f3 == 3'd0 || f3 == 3'd5) begin
        put(enc_r({1'b0, alt, 5'b0}, 5'd2, 5'd1, f3, 5'd5));
        put(`RV_NOP);
        put_sw(5'd5, addr, alu_model(f3, alt, a, b), 1'b1);
        imm = 12'($urandom());
        // Shift immediates carry the shift kind in bit 10
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm = {1'b0, alt, 5'b0, imm[4:0]};
        end
        put(enc_i(imm, 5'd1, f3, 5'd6, OP_IMM));
        put(`RV_NOP);
        put_sw(5'd6, addr + 12'd4, alu_model(f3, alt && f3 == 3'd5, a, sext12(imm)), 1'b1);
        addr = addr + 12'd8;
      end
    end
    upper = 20'($urandom());
    put(enc_u(upper, 5'd7));
    put(`RV_NOP);
    put_sw(5'd7, addr, {upper, 12'b0}, 1'b1);
    finish_program();
    release_reset();
    collect_stores("alu operations", 0);
  endtask

  task automatic test_load_store();
    rv_pkg::data_t v;
    begin_program();
    v = $urandom();
    put_pair(5'd1, v, 5'd2, ~v);
    put(`RV_NOP);
    put_sw(5'd1, 12'h300, v, 1'b1);
    put(`RV_NOP);
    put(enc_i(12'h300, 5'd0, 3'b010, 5'd8, OP_LOAD));
    put(`RV_NOP);
    put_sw(5'd8, 12'h304, v, 1'b1);
    finish_program();
    release_reset();
    collect_stores("store then load", 1);
  endtask

  task automatic test_branches();
    rv_pkg::data_t    a;
    rv_pkg::data_t    b;
    rv_pkg::data_t    tag;
    rv_pkg::data_t    va;
    rv_pkg::data_t    vb;
    rv_pkg::reg_idx_t s1;
    rv_pkg::reg_idx_t s2;
    logic [2:0]       f3;
    logic             odd;
    logic             taken;
    logic [11:0]      addr;
    begin_program();
    a   = $urandom();
    b   = $urandom();
    tag = $urandom();
    if (b == a) begin
      b = ~a;
    end
    put_pair(5'd1, a, 5'd2, b);
    put_pair(5'd3, a, 5'd4, tag);
    put(`RV_NOP);
    put(`RV_NOP);
    addr = 12'h200;
    for (int k = 0; k < 8; k++) begin
      f3  = (k < 2) ? 3'b000 : (k < 4) ? 3'b001 : (k < 6) ? 3'b100 : 3'b101;
      odd = 1'(k % 2);
      // x3 equals x1, so beq and bne see both outcomes
      if (!f3[2]) begin
        s1 = 5'd1;
        s2 = odd ? 5'd2 : 5'd3;
        va = a;
        vb = odd ? b : a;
      end else begin
        s1 = odd ? 5'd2 : 5'd1;
        s2 = odd ? 5'd1 : 5'd2;
        va = odd ? b : a;
        vb = odd ? a : b;
      end
      taken = branch_model(f3, va, vb);
      put(enc_b(13'd12, s2, s1, f3));
      put_sw(5'd4, addr, tag, !taken);
      put_sw(5'd4, addr + 12'd4, tag, !taken);
      put_sw(5'd4, addr + 12'd8, tag, 1'b1);
      addr = addr + 12'd12;
    end
    finish_program();
    release_reset();
    collect_stores("conditional branches", 0);
  endtask

  task automatic test_jal();
    rv_pkg::addr_t    jal_pc;
    rv_pkg::reg_idx_t link;
    int               lead;
    begin_program();
    lead = $urandom() % 4;
    for (int i = 0; i < lead; i++) begin
      put(`RV_NOP);
    end
    for (int k = 0; k < 2; k++) begin
      link   = 5'(5 + k);
      jal_pc = `RV_RESET_PC + 32'(4 * prog_len);
      put(enc_j(21'd12, link));
      put_sw(link, 12'(12'h280 + 16 * k), 32'd0, 1'b0);
      put_sw(link, 12'(12'h284 + 16 * k), 32'd0, 1'b0);
      put_sw(link, 12'(12'h288 + 16 * k), jal_pc + 32'd4, 1'b1);
    end
    finish_program();
    release_reset();
    collect_stores("jal link and skip", 0);
  endtask

  task automatic test_x0_spacing();
    rv_pkg::data_t v;
    logic [11:0]   imm;
    begin_program();
    v   = $urandom();
    imm = 12'($urandom());
    put(enc_i(imm, 5'd0, 3'b000, 5'd0, OP_IMM));
    put(`RV_NOP);
    put_sw(5'd0, 12'h2C0, 32'd0, 1'b1);
    // Consumer of x1 sits exactly two slots after the lui
    put(enc_u(v[31:12], 5'd1));
    put(enc_i(imm, 5'd0, 3'b000, 5'd9, OP_IMM));
    put(enc_i(v[11:0], 5'd1, 3'b000, 5'd2, OP_IMM));
    put(`RV_NOP);
    put_sw(5'd2, 12'h2C4, {v[31:12], 12'b0} + sext12(v[11:0]), 1'b1);
    put_sw(5'd9, 12'h2C8, sext12(imm), 1'b1);
    finish_program();
    release_reset();
    collect_stores("x0 and operand spacing", 0);
  endtask

  initial begin
    seed = 82830;
    void'($urandom(seed));
    reset        = 1'b1;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_errors  = 0;
    clear_memories();
    test_reset_fetch();
    test_alu_ops();
    test_load_store();
    test_branches();
    test_jal();
    test_x0_spacing();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+source
source/rv_pkg.sv
source/alu.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/rv_core.sv
testbench/clock_gen.sv
testbench/core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_pkg.sv
      - source/alu.sv
      - source/register_file.sv
      - source/fetch_stage.sv
      - source/decode_stage.sv
      - source/execute_stage.sv
      - source/memory_stage.sv
      - source/rv_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/clock_gen.sv
      - testbench/core_tb.sv
